//--- logic/sensor_cmd_pkg.sv
package sensor_cmd_pkg;

    typedef logic [7:0]  cmd_byte_t;   // one byte of the serial command port
    typedef logic [10:0] cmd_addr_t;   // register address, upper AH bits ignored
    typedef logic [31:0] cmd_data_t;   // D3..D0 assembled

    // address map
    localparam cmd_addr_t SENSOR_BASE_ADDR  = 11'h300; // channel base
    localparam cmd_addr_t SENSOR_CTRL_RADDR = 11'h000; // mode register
    localparam cmd_addr_t SENS_GAMMA_RADDR  = 11'h005; // gamma address/data register

    // command framing
    localparam int CMD_NUM_BYTES = 6; // AL, AH, D0, D1, D2, D3

    // gamma address/data register
    localparam int GAMMA_ADDR_FLAG_BIT = 20; // set for table address, clear for entry data

    // mode register
    localparam int SENSOR_16BIT_BIT = 8; // 1 selects raw 16-bit output

    // target of a decoded write
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0, // idle cycle
        CMD_MODE  = 2'd1, // mode register
        CMD_GAMMA = 2'd2  // gamma table address or entry
    } cmd_sel_e;

    // one decoded write, valid for one cycle when sel is not none
    typedef struct packed {
        cmd_sel_e  sel;  // target
        cmd_data_t data; // payload
    } cmd_wr_t;

endpackage

//--- logic/sensor_pix_pkg.sv
package sensor_pix_pkg;

    typedef logic [11:0] pxd_t;        // sensor pixel
    typedef logic [7:0]  gamma_t;      // gamma table output
    typedef logic [7:0]  gamma_addr_t; // table index
    typedef logic [15:0] out_word_t;   // word toward memory

    localparam int GAMMA_INDEX_LSB   = 4;   // top 8 pixel bits index the table
    localparam int GAMMA_TABLE_DEPTH = 256; // one entry per index value

    // zero fill below the raw pixel in 16-bit mode
    localparam int OUT_PAD_BITS = $bits(out_word_t) - $bits(pxd_t);

    // pixel stream from the sensor side
    typedef struct packed {
        pxd_t pxd;  // pixel value
        logic hact; // line active, pixel valid
        logic sof;  // start of frame pulse
        logic eof;  // end of frame pulse
    } pix_stream_t;

    // after the table lookup, raw pixel kept alongside
    typedef struct packed {
        pxd_t   pxd;   // raw pixel for 16-bit mode
        gamma_t gamma; // looked-up byte for 8-bit mode
        logic   hact;  // line active
        logic   sof;   // start of frame
        logic   eof;   // end of frame
    } gamma_stream_t;

endpackage

//--- logic/cmd_deser.sv
`timescale 1ns/1ps

module cmd_deser #(
    parameter sensor_cmd_pkg::cmd_addr_t BASE_ADDR = sensor_cmd_pkg::SENSOR_BASE_ADDR
) (
    input  logic                      mclk,
    input  logic                      rst,
    input  sensor_cmd_pkg::cmd_byte_t cmd_ad_i,  // AL, AH, D0..D3 on consecutive cycles
    input  logic                      cmd_stb_i, // high with the first byte only
    output sensor_cmd_pkg::cmd_wr_t   cmd_wr_o   // one-cycle decoded write
);
    import sensor_cmd_pkg::*;

    localparam int BYTE_W = $bits(cmd_byte_t);
    localparam int CNT_W  = $clog2(CMD_NUM_BYTES);
    localparam int SHR_W  = BYTE_W * (CMD_NUM_BYTES - 1); // all but the last byte

    localparam cmd_addr_t CTRL_ADDR  = cmd_addr_t'(BASE_ADDR + SENSOR_CTRL_RADDR);
    localparam cmd_addr_t GAMMA_ADDR = cmd_addr_t'(BASE_ADDR + SENS_GAMMA_RADDR);

    typedef enum logic {
        IDLE,   // waiting for a strobe
        COLLECT // bytes 1..5 arriving
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] byte_cnt;  // index of the byte now in ad_r
    cmd_byte_t        ad_r;      // input register stage
    logic             stb_r;
    logic [SHR_W-1:0] shreg;     // b0 ends at the lsb
    logic             last_byte; // ad_r holds D3
    logic             shift_en;
    cmd_addr_t        addr_w;
    cmd_data_t        data_w;
    cmd_sel_e         sel_w;
    cmd_sel_e         wr_sel;
    cmd_data_t        wr_data;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            stb_r <= 1'b0;
        end else begin
            stb_r <= cmd_stb_i;
        end
    end

    always_ff @(posedge mclk) begin
        ad_r <= cmd_ad_i; // byte follows the strobe pipeline
    end

    assign last_byte = (state == COLLECT) && (byte_cnt == CNT_W'(CMD_NUM_BYTES - 1));
    assign shift_en  = ((state == IDLE) && stb_r) || ((state == COLLECT) && !last_byte);

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (stb_r) begin
                        state    <= COLLECT;
                        byte_cnt <= CNT_W'(1); // next byte is AH
                    end
                end
                COLLECT: begin
                    if (last_byte) begin
                        state <= IDLE;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (shift_en) begin
            shreg <= {ad_r, shreg[SHR_W-1:BYTE_W]}; // shift right, newest on top
        end
    end

    assign addr_w = shreg[$bits(cmd_addr_t)-1:0];          // {AH, AL}
    assign data_w = {ad_r, shreg[SHR_W-1:2*BYTE_W]};      // {D3, D2, D1, D0}

    always_comb begin
        sel_w = CMD_NONE;
        if (last_byte) begin
            if (addr_w == CTRL_ADDR) begin
                sel_w = CMD_MODE;
            end else if (addr_w == GAMMA_ADDR) begin
                sel_w = CMD_GAMMA;
            end
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            wr_sel <= CMD_NONE;
        end else begin
            wr_sel <= sel_w; // decode stage register
        end
    end

    always_ff @(posedge mclk) begin
        if (last_byte) begin
            wr_data <= data_w;
        end
    end

    assign cmd_wr_o = '{sel: wr_sel, data: wr_data};

    // a new command may only start after the sixth byte
    a_no_stb_in_cmd: assert property (@(posedge mclk) disable iff (rst)
        (state == COLLECT) |-> !stb_r)
        else $error("cmd_deser: strobe while a command is being collected");

endmodule

//--- logic/gamma_lut.sv
`timescale 1ns/1ps

module gamma_lut (
    input  logic                          mclk,
    input  logic                          rst,
    input  sensor_cmd_pkg::cmd_wr_t       cmd_wr_i, // decoded register write
    input  sensor_pix_pkg::pix_stream_t   pix_i,    // one pixel per cycle while hact
    output sensor_pix_pkg::gamma_stream_t gamma_o   // pix_i delayed by 2, with lookup
);
    import sensor_cmd_pkg::*;
    import sensor_pix_pkg::*;

    gamma_t      gamma_mem [GAMMA_TABLE_DEPTH]; // loadable table, no reset
    gamma_addr_t wr_idx;                        // auto-incrementing write pointer
    logic        gamma_wr;
    logic        idx_we;                        // table address write
    logic        tbl_we;                        // table entry write

    pxd_t        s1_pxd;  // stage 1, registered input
    logic        s1_hact;
    logic        s1_sof;
    logic        s1_eof;
    gamma_addr_t rd_idx;  // top pixel bits

    pxd_t        s2_pxd;  // stage 2, lookup result
    gamma_t      s2_gamma;
    logic        s2_hact;
    logic        s2_sof;
    logic        s2_eof;

    assign gamma_wr = (cmd_wr_i.sel == CMD_GAMMA);
    assign idx_we   = gamma_wr && cmd_wr_i.data[GAMMA_ADDR_FLAG_BIT];
    assign tbl_we   = gamma_wr && !cmd_wr_i.data[GAMMA_ADDR_FLAG_BIT];

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            wr_idx <= '0;
        end else if (idx_we) begin
            wr_idx <= cmd_wr_i.data[$bits(gamma_addr_t)-1:0]; // set index
        end else if (tbl_we) begin
            wr_idx <= wr_idx + 1'b1; // step after each entry
        end
    end

    always_ff @(posedge mclk) begin
        if (tbl_we) begin
            gamma_mem[wr_idx] <= cmd_wr_i.data[$bits(gamma_t)-1:0]; // low byte only
        end
    end

    // line and frame flags through both stages
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            s1_hact <= 1'b0;
            s1_sof  <= 1'b0;
            s1_eof  <= 1'b0;
            s2_hact <= 1'b0;
            s2_sof  <= 1'b0;
            s2_eof  <= 1'b0;
        end else begin
            s1_hact <= pix_i.hact;
            s1_sof  <= pix_i.sof;
            s1_eof  <= pix_i.eof;
            s2_hact <= s1_hact;
            s2_sof  <= s1_sof;
            s2_eof  <= s1_eof;
        end
    end

    assign rd_idx = s1_pxd[GAMMA_INDEX_LSB +: $bits(gamma_addr_t)];

    always_ff @(posedge mclk) begin
        s1_pxd   <= pix_i.pxd;
        s2_pxd   <= s1_pxd;            // raw pixel kept for 16-bit mode
        s2_gamma <= gamma_mem[rd_idx]; // synchronous read
    end

    assign gamma_o = '{pxd: s2_pxd, gamma: s2_gamma, hact: s2_hact, sof: s2_sof, eof: s2_eof};

    // frame pulses are distinct events on the sensor side
    a_sof_eof_apart: assert property (@(posedge mclk) disable iff (rst)
        pix_i.sof |-> !pix_i.eof)
        else $error("gamma_lut: sof and eof in the same cycle");

endmodule

//--- logic/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer (
    input  logic                          mclk,
    input  logic                          rst,
    input  sensor_cmd_pkg::cmd_wr_t       cmd_wr_i,     // decoded register write
    input  sensor_pix_pkg::gamma_stream_t gamma_i,      // from the lookup
    output sensor_pix_pkg::out_word_t     dout_o,       // raw or two packed bytes
    output logic                          dout_valid_o, // alternates in 8-bit mode
    output logic                          sof_o,        // start of frame, same delay as data
    output logic                          eof_o         // end of frame, same delay as data
);
    import sensor_cmd_pkg::*;
    import sensor_pix_pkg::*;

    logic      bit16;    // mode register, 1 for raw 16-bit words
    logic      pair;     // second pixel of a pair is on gamma_i
    gamma_t    hi_byte;  // earlier byte of the pair
    out_word_t dout_w;
    logic      dav_w;
    out_word_t dout_r;
    logic      dav_r;
    logic      sof_r;
    logic      eof_r;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            bit16 <= 1'b0; // 8-bit mode after reset
        end else if (cmd_wr_i.sel == CMD_MODE) begin
            bit16 <= cmd_wr_i.data[SENSOR_16BIT_BIT];
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pair <= 1'b0;
        end else begin
            pair <= gamma_i.hact && !pair; // toggles in the line, cleared between lines
        end
    end

    always_ff @(posedge mclk) begin
        if (gamma_i.hact && !pair) begin
            hi_byte <= gamma_i.gamma; // first of the pair
        end
    end

    // odd last pixel never reaches pair, so it is dropped
    assign dout_w = bit16 ? {gamma_i.pxd, {OUT_PAD_BITS{1'b0}}} : {hi_byte, gamma_i.gamma};
    assign dav_w  = bit16 ? gamma_i.hact : (gamma_i.hact && pair);

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            dav_r <= 1'b0;
            sof_r <= 1'b0;
            eof_r <= 1'b0;
        end else begin
            dav_r <= dav_w;
            sof_r <= gamma_i.sof; // same delay in both modes
            eof_r <= gamma_i.eof;
        end
    end

    always_ff @(posedge mclk) begin
        if (dav_w) begin
            dout_r <= dout_w; // holds between valid words
        end
    end

    assign dout_o       = dout_r;
    assign dout_valid_o = dav_r;
    assign sof_o        = sof_r;
    assign eof_o        = eof_r;

    // the mode that formed each word is the one a cycle earlier
    a_8bit_no_back_to_back: assert property (@(posedge mclk) disable iff (rst)
        (dav_r && $past(!bit16)) |=> (!dav_r || $past(bit16)))
        else $error("pixel_packer: consecutive valid words in 8-bit mode");

endmodule

//--- logic/sensor_channel.sv
`timescale 1ns/1ps

module sensor_channel #(
    parameter sensor_cmd_pkg::cmd_addr_t BASE_ADDR = sensor_cmd_pkg::SENSOR_BASE_ADDR
) (
    input  logic                        mclk,
    input  logic                        rst,
    // command port
    input  sensor_cmd_pkg::cmd_byte_t   cmd_ad_i,     // AL, AH, D0..D3
    input  logic                        cmd_stb_i,    // with the first byte
    // pixel input
    input  sensor_pix_pkg::pix_stream_t pix_i,        // pixel, hact, sof, eof
    // output toward memory, pix_i delayed by 3
    output sensor_pix_pkg::out_word_t   dout_o,       // 16-bit word
    output logic                        dout_valid_o, // word strobe
    output logic                        sof_o,        // start of frame pulse
    output logic                        eof_o         // end of frame pulse
);
    import sensor_cmd_pkg::*;
    import sensor_pix_pkg::*;

    cmd_wr_t       cmd_wr;       // decoded writes to both stages
    gamma_stream_t gamma_stream; // lookup result with raw pixel

    // decode
    cmd_deser #(
        .BASE_ADDR    (BASE_ADDR)
    ) cmd_deser_inst (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_ad_i     (cmd_ad_i),
        .cmd_stb_i    (cmd_stb_i),
        .cmd_wr_o     (cmd_wr)
    );

    // execute
    gamma_lut gamma_lut_inst (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_wr_i     (cmd_wr),
        .pix_i        (pix_i),
        .gamma_o      (gamma_stream)
    );

    // result
    pixel_packer pixel_packer_inst (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_wr_i     (cmd_wr),
        .gamma_i      (gamma_stream),
        .dout_o       (dout_o),
        .dout_valid_o (dout_valid_o),
        .sof_o        (sof_o),
        .eof_o        (eof_o)
    );

endmodule

//--- testbench/tb_sensor_tasks.svh
`ifndef TB_SENSOR_TASKS_SVH
`define TB_SENSOR_TASKS_SVH

// quiet inputs for n cycles
task automatic idle_cycles(input int n);
    repeat (n) begin
        @(negedge mclk);
        pix_i     = '0;
        cmd_stb_i = 1'b0;
        cmd_ad_i  = '0;
    end
endtask

// six bytes back to back: AL, AH, D0..D3
task automatic send_command(input cmd_addr_t addr, input cmd_data_t data);
    logic [47:0] bytes;
    bytes = {data, 5'd0, addr}; // AH carries only addr[10:8]
    for (int i = 0; i < 6; i++) begin
        @(negedge mclk);
        cmd_stb_i = (i == 0); // strobe with AL only
        cmd_ad_i  = bytes[8*i +: 8];
    end
endtask

task automatic set_mode(input logic bit16);
    send_command(cmd_addr_t'(BASE + 11'd0), {23'd0, bit16, 8'd0}); // mode bit 8
    model_16bit = bit16;
    idle_cycles(SETTLE);
endtask

task automatic point_gamma_index(input gamma_addr_t idx);
    send_command(cmd_addr_t'(BASE + 11'd5), {11'd0, 1'b1, 12'd0, idx}); // flag bit 20
    model_widx = idx;
endtask

// upper data bits are noise, only the low byte lands in the table
task automatic write_gamma_entry(input gamma_t val);
    cmd_data_t d;
    d       = $urandom;
    d[20]   = 1'b0; // entry write, not an index write
    d[7:0]  = val;
    send_command(cmd_addr_t'(BASE + 11'd5), d);
    model_table[model_widx] = val;
    model_widx = model_widx + 8'd1;
endtask

task automatic load_gamma_table();
    point_gamma_index(8'd0);
    for (int i = 0; i < 256; i++) begin
        write_gamma_entry(gamma_t'($urandom));
    end
    idle_cycles(SETTLE);
endtask

// one line of random pixels, about half of them aimed at hit_idx when use_hit
task automatic drive_line(input int len, input logic use_hit, input gamma_addr_t hit_idx);
    pxd_t px;
    for (int i = 0; i < len; i++) begin
        @(negedge mclk);
        px = pxd_t'($urandom);
        if (use_hit && ($urandom % 2 == 0)) begin
            px[11:4] = hit_idx; // top bits pick the table entry
        end
        pix_i = '{pxd: px, hact: 1'b1, sof: 1'b0, eof: 1'b0};
    end
    idle_cycles(LINE_GAP); // hact low ends the line
endtask

// single cycle frame strobe outside hact
task automatic pulse_frame(input logic is_sof);
    @(negedge mclk);
    pix_i = '{pxd: '0, hact: 1'b0, sof: is_sof, eof: !is_sof};
    idle_cycles(LINE_GAP);
endtask

`endif

//--- testbench/tb_sensor_channel.sv
`timescale 1ns/1ps

module tb_sensor_channel;
    import sensor_cmd_pkg::*;
    import sensor_pix_pkg::*;

    localparam cmd_addr_t BASE = SENSOR_BASE_ADDR;
    localparam int CLK_HALF  = 2;  // 4 ns period
    localparam int LINE_LEN  = 32;
    localparam int LINE_GAP  = 4;
    localparam int SETTLE    = 8;  // write latency plus slack
    localparam int CMD_BYTES = 6;
    localparam int LINE_CYC  = LINE_LEN + LINE_GAP;
    localparam int MODE_CYC  = CMD_BYTES + SETTLE;
    localparam int RUN_CYC   = 5 + 20                               // reset, idle test
                             + MODE_CYC + 4 * LINE_CYC              // raw lines
                             + 257 * CMD_BYTES + SETTLE + MODE_CYC + 4 * LINE_CYC
                             + 3 * CMD_BYTES + SETTLE + 3 * LINE_CYC
                             + 2 * CMD_BYTES + SETTLE + 3 * LINE_CYC
                             + 2 * (MODE_CYC + 2 * LINE_CYC + 2 * (1 + LINE_GAP))
                             + 10;                                  // flush
    localparam int WATCHDOG_NS = 2 * RUN_CYC * 2 * CLK_HALF + 400;

    typedef struct packed {
        logic [31:0] due;  // cycle the output is checked
        logic        dav;
        out_word_t   word;
        logic        sof;
        logic        eof;
    } exp_t;

    logic        mclk = 1'b0;
    logic        rst = 1'b1;
    cmd_byte_t   cmd_ad_i = '0;
    logic        cmd_stb_i = 1'b0;
    pix_stream_t pix_i = '0;
    out_word_t   dout_o;
    logic        dout_valid_o;
    logic        sof_o;
    logic        eof_o;

    gamma_t      model_table [256];  // mirror of the loaded table
    gamma_addr_t model_widx = '0;
    logic        model_16bit = 1'b0; // 8-bit mode after reset
    logic        model_pair = 1'b0;
    gamma_t      model_hi = '0;
    exp_t        exp_q [$];
    exp_t        cur = '0;           // expectation for the coming posedge
    logic        exp_chk = 1'b0;
    int unsigned cyc = 0;
    int          err_cnt = 0;
    int          err_mark = 0;
    int          test_cnt = 0;
    int          test_fail = 0;

    always #(CLK_HALF) mclk = ~mclk;

    sensor_channel #(
        .BASE_ADDR    (BASE)
    ) sensor_channel_inst (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_ad_i     (cmd_ad_i),
        .cmd_stb_i    (cmd_stb_i),
        .pix_i        (pix_i),
        .dout_o       (dout_o),
        .dout_valid_o (dout_valid_o),
        .sof_o        (sof_o),
        .eof_o        (eof_o)
    );

    `include "tb_sensor_tasks.svh"

    task automatic flag_mismatch(input string what, input out_word_t got, input out_word_t want);
        err_cnt++;
        $display("ERR %0t: %0s is %h, expected %h", $time, what, got, want);
    endtask

    task automatic note_test_start();
        err_mark = err_cnt;
    endtask

    task automatic summarize_test(input string name);
        test_cnt++;
        if (err_cnt != err_mark) begin
            test_fail++;
            $display("test %0s: %0d mismatches", name, err_cnt - err_mark);
        end else begin
            $display("test %0s: ok", name);
        end
    endtask

    // model, one expectation per input cycle, due 3 cycles later
    always @(posedge mclk) begin
        exp_t   e;
        gamma_t g;
        e.due  = cyc + 3;
        e.sof  = pix_i.sof;
        e.eof  = pix_i.eof;
        e.dav  = 1'b0;
        e.word = '0;
        g      = model_table[pix_i.pxd[11:4]];
        if (model_16bit) begin
            e.dav  = pix_i.hact;
            e.word = {pix_i.pxd, 4'h0}; // left aligned, zero fill
        end else if (pix_i.hact && model_pair) begin
            e.dav  = 1'b1;
            e.word = {model_hi, g};     // earlier byte on top
        end
        if (pix_i.hact && !model_pair) begin
            model_hi = g;
        end
        model_pair = pix_i.hact && !model_pair; // cleared between lines
        exp_q.push_back(e);
        cyc = cyc + 1;
    end

    // head of queue into cur, away from the sampling edge
    always @(negedge mclk) begin
        exp_chk = 1'b0;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            cur     = exp_q.pop_front();
            exp_chk = 1'b1;
        end
    end

    a_valid: assert property (@(posedge mclk) disable iff (rst)
        exp_chk |-> (dout_valid_o == cur.dav))
        else flag_mismatch("dout_valid_o", 16'($sampled(dout_valid_o)), 16'(cur.dav));
    a_word: assert property (@(posedge mclk) disable iff (rst)
        (exp_chk && cur.dav) |-> (dout_o == cur.word))
        else flag_mismatch("dout_o", $sampled(dout_o), cur.word);
    a_sof: assert property (@(posedge mclk) disable iff (rst)
        exp_chk |-> (sof_o == cur.sof))
        else flag_mismatch("sof_o", 16'($sampled(sof_o)), 16'(cur.sof));
    a_eof: assert property (@(posedge mclk) disable iff (rst)
        exp_chk |-> (eof_o == cur.eof))
        else flag_mismatch("eof_o", 16'($sampled(eof_o)), 16'(cur.eof));

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not complete within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        gamma_addr_t hit;
        void'($urandom(53076)); // single seed for the run
        repeat (5) @(negedge mclk);
        rst = 1'b0;

        note_test_start();
        idle_cycles(20); // outputs stay low with no pixels
        summarize_test("reset idle");

        note_test_start();
        set_mode(1'b1);
        repeat (4) drive_line(LINE_LEN, 1'b0, '0);
        summarize_test("16-bit raw");

        note_test_start();
        load_gamma_table();
        set_mode(1'b0);
        repeat (2) begin
            drive_line(LINE_LEN, 1'b0, '0);
            drive_line(LINE_LEN - 1, 1'b0, '0); // odd tail dropped
        end
        summarize_test("8-bit packed");

        note_test_start();
        send_command(cmd_addr_t'(BASE + 11'd3), 32'h0000_0100); // hole in the map
        send_command(cmd_addr_t'(BASE + 11'd4), 32'h0000_00a5);
        send_command(BASE ^ 11'h400, 32'h0000_0100);            // upper address bit differs
        idle_cycles(SETTLE);
        repeat (3) drive_line(LINE_LEN, 1'b1, model_widx); // entry a stray write would hit
        summarize_test("unmapped writes");

        note_test_start();
        hit = gamma_addr_t'($urandom);
        point_gamma_index(hit);
        write_gamma_entry(gamma_t'($urandom));
        idle_cycles(SETTLE);
        repeat (3) drive_line(LINE_LEN, 1'b1, hit);
        summarize_test("single entry reload");

        note_test_start();
        for (int m = 1; m >= 0; m--) begin
            set_mode(m[0]);
            pulse_frame(1'b1);
            repeat (2) drive_line(LINE_LEN, 1'b0, '0);
            pulse_frame(1'b0);
        end
        summarize_test("frame pulses");

        idle_cycles(10);
        $display("tests %0d, failed %0d, mismatches %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0 && test_fail == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+testbench
logic/sensor_cmd_pkg.sv
logic/sensor_pix_pkg.sv
logic/cmd_deser.sv
logic/gamma_lut.sv
logic/pixel_packer.sv
logic/sensor_channel.sv
testbench/tb_sensor_channel.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sensor channel testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_sensor_channel \
    -o tb_sensor_channel

./obj_dir/tb_sensor_channel > sim.log 2>&1
cat sim.log

if grep -q -F "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q -F "Finished with no errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
